//--- common/fftAccel_consts.svh
`ifndef FFTACCEL_CONSTS_SVH
`define FFTACCEL_CONSTS_SVH

// signed width of each host sample part
`define SAMPLE_W 16

// stored and output part width, room for four-term sums
`define RESULT_W 18

// transform size and memory address width
`define FFT_POINTS 4
`define ADDR_W 2

`endif

//--- common/fftAccel_pkg.sv
`default_nettype none

package fftAccel_pkg;

    // controller sequence, F and I branches kept apart
    typedef enum logic [3:0] {
        INITIAL,
        IDLE,
        LOADF,
        LOADI,
        STARTF,
        STARTI,
        CALCF,
        CALCI,
        DONE
    } ctrlState_t;

    // butterfly schedule, one step per cycle
    typedef enum logic [2:0] {
        S1A,
        S1B,
        S2A,
        S2B,
        OFF
    } fftStep_t;

endpackage

`default_nettype wire

//--- common/ramPortIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "fftAccel_consts.svh"

// one port of the sample memory
// read data follows addr combinationally, write on clk when en and we
interface ramPortIf;

    logic                        en;
    logic                        we;
    logic [`ADDR_W-1:0]          addr;
    logic signed [`RESULT_W-1:0] wRe;
    logic signed [`RESULT_W-1:0] wIm;
    logic signed [`RESULT_W-1:0] rRe;
    logic signed [`RESULT_W-1:0] rIm;

    // side that issues accesses
    modport master (
        output en, we, addr, wRe, wIm,
        input  rRe, rIm
    );

    // memory side
    modport ram (
        input  en, we, addr, wRe, wIm,
        output rRe, rIm
    );

endinterface

`default_nettype wire

//--- fft/fftEngine.sv
`timescale 1ns/1ps
`default_nettype none

`include "fftAccel_consts.svh"

module fftEngine import fftAccel_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     startFFT,
    input  logic     loadInternal,
    input  logic     isIFFT,
    output logic     done,
    ramPortIf.master engA,
    ramPortIf.master engB
);

    fftStep_t step;
    logic     active;

    logic signed [`RESULT_W-1:0] bRe;
    logic signed [`RESULT_W-1:0] bIm;

    ////////////////////////////////////////////////////////////////////////////
    // butterfly schedule
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= OFF;
        end else if (startFFT) begin
            step <= S1A;
        end else begin
            case (step)
                S1A:     step <= S1B;
                S1B:     step <= S2A;
                S2A:     step <= S2B;
                default: step <= OFF;
            endcase
        end
    end

    // operand pairs, data sits in bit-reversed order
    always_comb begin
        case (step)
            S1A:     {engA.addr, engB.addr} = {`ADDR_W'(0), `ADDR_W'(1)};
            S1B:     {engA.addr, engB.addr} = {`ADDR_W'(2), `ADDR_W'(3)};
            S2A:     {engA.addr, engB.addr} = {`ADDR_W'(0), `ADDR_W'(2)};
            S2B:     {engA.addr, engB.addr} = {`ADDR_W'(1), `ADDR_W'(3)};
            default: {engA.addr, engB.addr} = '0;
        endcase
    end

    assign active  = (step != OFF);
    assign engA.en = active;
    assign engB.en = active;
    assign engA.we = active && loadInternal;
    assign engB.we = active && loadInternal;

    ////////////////////////////////////////////////////////////////////////////
    // twiddle and sum/difference
    ////////////////////////////////////////////////////////////////////////////

    // last butterfly rotates b by -j, or +j for the inverse
    always_comb begin
        bRe = engB.rRe;
        bIm = engB.rIm;
        if (step == S2B) begin
            if (isIFFT) begin
                bRe = -engB.rIm;
                bIm = engB.rRe;
            end else begin
                bRe = engB.rIm;
                bIm = -engB.rRe;
            end
        end
    end

    assign engA.wRe = engA.rRe + bRe;
    assign engA.wIm = engA.rIm + bIm;
    assign engB.wRe = engA.rRe - bRe;
    assign engB.wIm = engA.rIm - bIm;

    assign done = (step == S2B);

endmodule

`default_nettype wire

//--- fft/sampleRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "fftAccel_consts.svh"

module sampleRam (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        loadInternal,
    input  logic [`ADDR_W-1:0]          rdAddr,
    ramPortIf.ram                       ldPort,
    ramPortIf.ram                       engA,
    ramPortIf.ram                       engB,
    output logic signed [`RESULT_W-1:0] rdRe,
    output logic signed [`RESULT_W-1:0] rdIm
);

    logic signed [`RESULT_W-1:0] memRe [`FFT_POINTS];
    logic signed [`RESULT_W-1:0] memIm [`FFT_POINTS];

    ////////////////////////////////////////////////////////////////////////////
    // writes, engine ports take over during the calculation
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FFT_POINTS; i++) begin
                memRe[i] <= '0;
                memIm[i] <= '0;
            end
        end else if (loadInternal) begin
            // engine addresses never collide within a step
            if (engA.en && engA.we) begin
                memRe[engA.addr] <= engA.wRe;
                memIm[engA.addr] <= engA.wIm;
            end
            if (engB.en && engB.we) begin
                memRe[engB.addr] <= engB.wRe;
                memIm[engB.addr] <= engB.wIm;
            end
        end else if (ldPort.en && ldPort.we) begin
            memRe[ldPort.addr] <= ldPort.wRe;
            memIm[ldPort.addr] <= ldPort.wIm;
        end
    end

    // combinational reads
    assign engA.rRe   = memRe[engA.addr];
    assign engA.rIm   = memIm[engA.addr];
    assign engB.rRe   = memRe[engB.addr];
    assign engB.rIm   = memIm[engB.addr];
    assign ldPort.rRe = memRe[ldPort.addr];
    assign ldPort.rIm = memIm[ldPort.addr];
    assign rdRe       = memRe[rdAddr];
    assign rdIm       = memIm[rdAddr];

endmodule

`default_nettype wire

//--- fftAccel.f
+incdir+common
common/fftAccel_pkg.sv
common/ramPortIf.sv
logic/control.sv
logic/sampleLoader.sv
fft/sampleRam.sv
fft/fftEngine.sv
logic/fftAccel.sv
testbench/fftAccel_sva.sv
testbench/tb_fftAccel.sv

//--- logic/control.sv
`timescale 1ns/1ps
`default_nettype none

module control import fftAccel_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic startF,
    input  logic startI,
    input  logic loadExternalDone,
    input  logic done,
    output logic calculating,
    output logic loadExternal,
    output logic loadInternal,
    output logic isIFFT,
    output logic startFFT,
    output logic aDone,
    output logic idle
);

    ctrlState_t state;
    ctrlState_t nextState;

    ////////////////////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= INITIAL;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state and Moore outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState    = state;
        calculating  = 1'b0;
        loadExternal = 1'b0;
        loadInternal = 1'b0;
        isIFFT       = 1'b0;
        startFFT     = 1'b0;
        aDone        = 1'b0;
        idle         = 1'b0;

        case (state)
            INITIAL: nextState = IDLE;
            IDLE: begin
                idle = 1'b1;
                // forward wins when both arrive together
                if (startF) begin
                    nextState = LOADF;
                end else if (startI) begin
                    nextState = LOADI;
                end
            end
            // host streams samples in
            LOADF, LOADI: begin
                loadExternal = 1'b1;
                if (loadExternalDone) begin
                    nextState = (state == LOADF) ? STARTF : STARTI;
                end
            end
            STARTF, STARTI: begin
                startFFT  = 1'b1;
                nextState = (state == STARTF) ? CALCF : CALCI;
            end
            // engine owns the memory here
            CALCF, CALCI: begin
                calculating  = 1'b1;
                loadInternal = 1'b1;
                isIFFT       = (state == CALCI);
                if (done) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                aDone     = 1'b1;
                nextState = IDLE;
            end
            default: nextState = INITIAL;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/fftAccel.sv
`timescale 1ns/1ps
`default_nettype none

`include "fftAccel_consts.svh"

module fftAccel (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        startF,
    input  logic                        startI,
    input  logic                        inValid,
    input  logic signed [`SAMPLE_W-1:0] inRe,
    input  logic signed [`SAMPLE_W-1:0] inIm,
    input  logic [`ADDR_W-1:0]          rdAddr,
    output logic                        loadReq,
    output logic                        busy,
    output logic                        idle,
    output logic                        resultDone,
    output logic signed [`RESULT_W-1:0] rdRe,
    output logic signed [`RESULT_W-1:0] rdIm
);

    logic loadExternal;
    logic loadInternal;
    logic loadExternalDone;
    logic startFFT;
    logic isIFFT;
    logic done;

    ramPortIf ldPort ();
    ramPortIf engA ();
    ramPortIf engB ();

    control u_control (
        .clk              (clk),
        .rst              (rst),
        .startF           (startF),
        .startI           (startI),
        .loadExternalDone (loadExternalDone),
        .done             (done),
        .calculating      (busy),
        .loadExternal     (loadExternal),
        .loadInternal     (loadInternal),
        .isIFFT           (isIFFT),
        .startFFT         (startFFT),
        .aDone            (resultDone),
        .idle             (idle)
    );

    // host handshake is the load level itself
    assign loadReq = loadExternal;

    sampleLoader u_loader (
        .clk              (clk),
        .rst              (rst),
        .loadExternal     (loadExternal),
        .inValid          (inValid),
        .inRe             (inRe),
        .inIm             (inIm),
        .loadExternalDone (loadExternalDone),
        .ldPort           (ldPort.master)
    );

    sampleRam u_ram (
        .clk          (clk),
        .rst          (rst),
        .loadInternal (loadInternal),
        .rdAddr       (rdAddr),
        .ldPort       (ldPort.ram),
        .engA         (engA.ram),
        .engB         (engB.ram),
        .rdRe         (rdRe),
        .rdIm         (rdIm)
    );

    fftEngine u_engine (
        .clk          (clk),
        .rst          (rst),
        .startFFT     (startFFT),
        .loadInternal (loadInternal),
        .isIFFT       (isIFFT),
        .done         (done),
        .engA         (engA.master),
        .engB         (engB.master)
    );

endmodule

`default_nettype wire

//--- logic/sampleLoader.sv
`timescale 1ns/1ps
`default_nettype none

`include "fftAccel_consts.svh"

module sampleLoader (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       loadExternal,
    input  logic                       inValid,
    input  logic signed [`SAMPLE_W-1:0] inRe,
    input  logic signed [`SAMPLE_W-1:0] inIm,
    output logic                       loadExternalDone,
    ramPortIf.master                   ldPort
);

    logic [`ADDR_W-1:0] sampleCnt;
    logic               accept;

    // samples only count while the controller asks for them
    assign accept = loadExternal && inValid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sampleCnt <= '0;
        end else if (!loadExternal) begin
            sampleCnt <= '0;
        end else if (inValid) begin
            sampleCnt <= sampleCnt + 1'b1;
        end
    end

    // bit-reversed address, sign extended data
    assign ldPort.en   = accept;
    assign ldPort.we   = accept;
    assign ldPort.addr = {sampleCnt[0], sampleCnt[1]};
    assign ldPort.wRe  = `RESULT_W'(inRe);
    assign ldPort.wIm  = `RESULT_W'(inIm);

    // last sample of the block
    assign loadExternalDone = accept && (sampleCnt == `ADDR_W'(`FFT_POINTS - 1));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the fftAccel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fftAccel \
    -f fftAccel.f -o tb_fftAccel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_fftAccel)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- testbench/fftAccel_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fftAccel_sva (
    input logic clk,
    input logic rst,
    input logic calculating,
    input logic loadExternal,
    input logic done,
    input logic aDone
);

    // four butterflies, one per cycle
    property calcLength;
        @(posedge clk) disable iff (rst)
            $rose(calculating) |-> calculating ##1 calculating ##1 calculating
                ##1 calculating ##1 !calculating;
    endproperty

    assert property (calcLength) else $error("calculating did not last four cycles");

    assert property (@(posedge clk) disable iff (rst) done |=> aDone)
        else $error("aDone did not follow done");

    assert property (@(posedge clk) disable iff (rst) !(loadExternal && calculating))
        else $error("loading and calculating at the same time");

endmodule

bind control fftAccel_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .calculating  (calculating),
    .loadExternal (loadExternal),
    .done         (done),
    .aDone        (aDone)
);

`default_nettype wire

//--- testbench/tb_fftAccel.sv
`timescale 1ns/1ps
`default_nettype none

`include "fftAccel_consts.svh"

module tb_fftAccel;

    localparam int ENTRIES    = 8;
    localparam int WAIT_LIMIT = 50;

    logic                        clk;
    logic                        rst;
    logic                        startF;
    logic                        startI;
    logic                        inValid;
    logic signed [`SAMPLE_W-1:0] inRe;
    logic signed [`SAMPLE_W-1:0] inIm;
    logic [`ADDR_W-1:0]          rdAddr;
    logic                        loadReq;
    logic                        busy;
    logic                        idle;
    logic                        resultDone;
    logic signed [`RESULT_W-1:0] rdRe;
    logic signed [`RESULT_W-1:0] rdIm;

    // mode 0 forward, 1 inverse, 2 both starts in the same cycle
    int mode  [ENTRIES];
    int smpRe [ENTRIES][4];
    int smpIm [ENTRIES][4];
    bit junk  [ENTRIES];
    bit poke  [ENTRIES];

    int expRe [4];
    int expIm [4];
    int errorCount;
    int timeoutCount;

    fftAccel u_dut (
        .clk        (clk),
        .rst        (rst),
        .startF     (startF),
        .startI     (startI),
        .inValid    (inValid),
        .inRe       (inRe),
        .inIm       (inIm),
        .rdAddr     (rdAddr),
        .loadReq    (loadReq),
        .busy       (busy),
        .idle       (idle),
        .resultDone (resultDone),
        .rdRe       (rdRe),
        .rdIm       (rdIm)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int randSample();
        logic [31:0] r;
        r = $urandom;
        return int'($signed(r[15:0]));
    endfunction

    task automatic setEntry(input int idx, input int m, input bit j, input bit p,
                            input int r0, input int r1, input int r2, input int r3,
                            input int i0, input int i1, input int i2, input int i3);
        mode[idx]     = m;
        junk[idx]     = j;
        poke[idx]     = p;
        smpRe[idx][0] = r0;
        smpRe[idx][1] = r1;
        smpRe[idx][2] = r2;
        smpRe[idx][3] = r3;
        smpIm[idx][0] = i0;
        smpIm[idx][1] = i1;
        smpIm[idx][2] = i2;
        smpIm[idx][3] = i3;
    endtask

    task automatic fillTable();
        setEntry(0, 0, 0, 0, 1, 2, 3, 4, 0, 0, 0, 0);
        setEntry(1, 1, 0, 0, 100, -200, 300, -400, 5, 6, -7, 8);
        // full-scale negative everywhere
        setEntry(2, 0, 0, 0, -32768, -32768, -32768, -32768,
                 -32768, -32768, -32768, -32768);
        setEntry(3, 1, 0, 1, 32767, -32768, 32767, -32768, -32768, 32767, 32767, -32768);
        setEntry(4, 0, 1, 0, randSample(), randSample(), randSample(), randSample(),
                 randSample(), randSample(), randSample(), randSample());
        setEntry(5, 1, 1, 1, randSample(), randSample(), randSample(), randSample(),
                 randSample(), randSample(), randSample(), randSample());
        setEntry(6, 2, 0, 0, -1, 7, -13, 21, 9, -9, 4, -4);
        setEntry(7, 0, 1, 1, 1000, 0, -1000, 0, 0, 1000, 0, -1000);
    endtask

    // X1 = (a-c) + s*j*(b-d), X3 = (a-c) - s*j*(b-d), s = -1 forward, +1 inverse
    task automatic modelTransform(input int idx);
        int s;
        int acRe;
        int acIm;
        int bdRe;
        int bdIm;
        s     = (mode[idx] == 1) ? 1 : -1;
        acRe  = smpRe[idx][0] - smpRe[idx][2];
        acIm  = smpIm[idx][0] - smpIm[idx][2];
        bdRe  = smpRe[idx][1] - smpRe[idx][3];
        bdIm  = smpIm[idx][1] - smpIm[idx][3];
        expRe[0] = smpRe[idx][0] + smpRe[idx][1] + smpRe[idx][2] + smpRe[idx][3];
        expIm[0] = smpIm[idx][0] + smpIm[idx][1] + smpIm[idx][2] + smpIm[idx][3];
        expRe[2] = smpRe[idx][0] - smpRe[idx][1] + smpRe[idx][2] - smpRe[idx][3];
        expIm[2] = smpIm[idx][0] - smpIm[idx][1] + smpIm[idx][2] - smpIm[idx][3];
        expRe[1] = acRe - s * bdIm;
        expIm[1] = acIm + s * bdRe;
        expRe[3] = acRe + s * bdIm;
        expIm[3] = acIm - s * bdRe;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks and waits
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkBit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            errorCount++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic checkPart(input string name, input int addr,
                             input logic [`RESULT_W-1:0] got, input int want);
        logic [`RESULT_W-1:0] w;
        w = `RESULT_W'(want);
        assert (got === w) else begin
            errorCount++;
            $display("** Error: %s at address %0d = 0x%h, expected 0x%h", name, addr, got, w);
        end
    endtask

    // wantLoad selects loadReq, otherwise idle
    task automatic waitFor(input bit wantLoad, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!(wantLoad ? loadReq : idle) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(wantLoad ? loadReq : idle)) begin
            timeoutCount++;
            $display("timed out waiting for %s to go high", what);
        end
    endtask

    task automatic runEntry(input int idx);
        int busyCycles;
        int n;
        waitFor(1'b0, "idle");
        if (timeoutCount != 0) return;
        if (junk[idx]) begin
            // stray strobe while idle
            @(posedge clk);
            inValid <= 1'b1;
            inRe    <= `SAMPLE_W'($urandom);
            inIm    <= `SAMPLE_W'($urandom);
        end
        @(posedge clk);
        inValid <= 1'b0;
        startF  <= (mode[idx] != 1);
        startI  <= (mode[idx] != 0);
        @(posedge clk);
        startF <= 1'b0;
        startI <= 1'b0;
        waitFor(1'b1, "loadReq");
        if (timeoutCount != 0) return;
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            inValid <= 1'b1;
            inRe    <= `SAMPLE_W'(smpRe[idx][k]);
            inIm    <= `SAMPLE_W'(smpIm[idx][k]);
        end
        @(posedge clk);
        inValid <= junk[idx];
        inRe    <= `SAMPLE_W'($urandom);
        inIm    <= `SAMPLE_W'($urandom);
        // START cycle
        @(negedge clk);
        checkBit("loadReq", loadReq, 1'b0);
        checkBit("busy", busy, 1'b0);
        busyCycles = 0;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            inValid <= junk[idx];
            inRe    <= `SAMPLE_W'($urandom);
            inIm    <= `SAMPLE_W'($urandom);
            startF  <= poke[idx] && (busyCycles == 1);
            startI  <= poke[idx] && (busyCycles == 1);
            @(negedge clk);
            if (!busy) break;
            busyCycles++;
            checkBit("loadReq", loadReq, 1'b0);
        end
        if (busy) begin
            timeoutCount++;
            $display("timed out waiting for busy to drop");
            return;
        end
        assert (busyCycles == 4) else begin
            errorCount++;
            $display("** Error: busy cycles = 0x%h, expected 0x4", busyCycles);
        end
        checkBit("resultDone", resultDone, 1'b1);
        checkBit("idle", idle, 1'b0);
        @(posedge clk);
        inValid <= 1'b0;
        startF  <= 1'b0;
        startI  <= 1'b0;
        @(negedge clk);
        checkBit("resultDone", resultDone, 1'b0);
        checkBit("idle", idle, 1'b1);
        // readback, an ignored start must leave loadReq low
        modelTransform(idx);
        for (int a = 0; a < 4; a++) begin
            @(posedge clk);
            rdAddr <= `ADDR_W'(a);
            @(negedge clk);
            checkPart("rdRe", a, rdRe, expRe[a]);
            checkPart("rdIm", a, rdIm, expIm[a]);
            checkBit("loadReq", loadReq, 1'b0);
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'hf084_a52a));
        clk          = 1'b0;
        rst          = 1'b1;
        startF       = 1'b0;
        startI       = 1'b0;
        inValid      = 1'b0;
        inRe         = '0;
        inIm         = '0;
        rdAddr       = '0;
        errorCount   = 0;
        timeoutCount = 0;
        fillTable();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkBit("loadReq", loadReq, 1'b0);
        checkBit("busy", busy, 1'b0);
        checkBit("resultDone", resultDone, 1'b0);
        n = 0;
        while (!idle && n < 2) begin
            @(negedge clk);
            n++;
        end
        assert (idle) else begin
            errorCount++;
            $display("idle did not rise within two cycles after reset");
        end

        for (int i = 0; i < ENTRIES; i++) begin
            if (timeoutCount == 0) begin
                runEntry(i);
            end
        end

        $display("errors: %0d check, %0d timeout", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
